// File: Makefile
# Verilator flow for the pipeline control testbench
# run from the project root so the trace path resolves

VERILATOR ?= verilator
TOP       ?= tb_pipeline_ctrl
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result
sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/pipe_trace.txt
# c rst instr ihit dhit rdat1 rdat2 | expected imem_addr dmem_ren dmem_wen halt, all hex
# test lines name the group of cycles that follows, expected values after each rising edge
test seq_fetch
c 0 20010005 1 0 00000000 00000000 00000004 0 0 0
c 0 00000000 1 0 00000000 00000000 00000008 0 0 0
c 0 00000000 0 0 00000000 00000000 00000008 0 0 0
c 0 00000000 1 1 00000000 00000000 00000008 0 0 0
c 0 00000000 1 0 00000000 00000000 0000000c 0 0 0
c 0 00000000 1 0 00000000 00000000 00000010 0 0 0
test branch_mispredict
c 0 10220004 1 0 00000000 00000000 00000014 0 0 0
c 0 20010005 1 0 00000001 00000002 00000024 0 0 0
c 0 ac230000 1 0 00000000 00000000 00000028 0 0 0
c 0 8c220000 1 0 00000000 00000000 00000014 0 0 0
c 0 20010005 1 0 00000000 00000000 00000018 0 0 0
c 0 00000000 1 0 00000000 00000000 0000001c 0 0 0
test jumps
c 0 08000010 1 0 00000000 00000000 00000020 0 0 0
c 0 00000000 1 0 00000000 00000000 00000040 0 0 0
c 0 03e00008 1 0 00000000 00000000 00000044 0 0 0
c 0 00000000 1 0 00000060 00000000 00000060 0 0 0
c 0 00000000 1 0 00000000 00000000 00000064 0 0 0
test load_use
c 0 8c220000 1 0 00000000 00000000 00000068 0 0 0
c 0 00412020 1 0 00000000 00000000 0000006c 0 0 0
c 0 00000000 1 0 00000000 00000000 0000006c 1 0 0
c 0 00000000 1 1 00000000 00000000 00000070 0 0 0
c 0 8c220000 1 0 00000000 00000000 00000074 0 0 0
c 0 00000000 1 0 00000000 00000000 00000078 0 0 0
c 0 00000000 1 0 00000000 00000000 0000007c 1 0 0
c 0 00000000 1 0 00000000 00000000 0000007c 1 0 0
c 0 00000000 1 0 00000000 00000000 0000007c 1 0 0
c 0 00000000 1 1 00000000 00000000 00000080 0 0 0
test store_halt_reset
c 0 ac230000 1 0 00000000 00000000 00000084 0 0 0
c 0 fc000000 1 0 00000000 00000000 00000088 0 0 0
c 0 00000000 1 0 00000000 00000000 0000008c 0 1 0
c 0 00000000 1 0 00000000 00000000 0000008c 0 1 0
c 0 00000000 1 1 00000000 00000000 00000090 0 0 0
c 0 00000000 1 0 00000000 00000000 00000094 0 0 1
c 0 00000000 1 0 00000000 00000000 00000094 0 0 1
c 0 00000000 1 1 00000000 00000000 00000094 0 0 1
c 1 00000000 0 0 00000000 00000000 00000000 0 0 0
c 0 00000000 0 0 00000000 00000000 00000000 0 0 0

// File: dv/tb_clock_gen.sv
// testbench clock generator
// free running clock with a 4 ns period

`timescale 1ns/100ps

module tb_clock_gen (
	output logic CLK
);

	// toggle every half period, first rising edge at 2 ns
	initial begin
		CLK = 1'b0;
		forever begin
			#2 CLK = ~CLK;
		end
	end

endmodule

// File: dv/tb_pipeline_ctrl.sv
// pipeline control testbench
// replays a cycle trace into the top level, drives inputs on the
// falling edge and compares outputs just before the next falling edge

`timescale 1ns/100ps
`include "cpu_consts.svh"

module tb_pipeline_ctrl;

	logic               CLK;
	logic               rst;
	logic [`WORD_W-1:0] instr;
	logic               ihit;
	logic               dhit;
	logic [`WORD_W-1:0] rdat1;
	logic [`WORD_W-1:0] rdat2;
	logic [`WORD_W-1:0] imem_addr;
	logic               dmem_ren;
	logic               dmem_wen;
	logic               halt;

	// whole trace, read before reset is released
	string trace_lines[$];
	string test_name;
	int    test_open = 0;
	int    test_errs = 0;
	int    test_cycles = 0;
	int    pass_count = 0;
	int    fail_count = 0;
	int    cycle_count = 0;
	int    cycle_limit = 0;

	tb_clock_gen u_clk (
		.CLK (CLK)
	);

	pipeline_ctrl_top uut (
		.CLK       (CLK),
		.rst       (rst),
		.instr     (instr),
		.ihit      (ihit),
		.dhit      (dhit),
		.rdat1     (rdat1),
		.rdat2     (rdat2),
		.imem_addr (imem_addr),
		.dmem_ren  (dmem_ren),
		.dmem_wen  (dmem_wen),
		.halt      (halt)
	);

	// run guard, limit is set once the trace length is known
	always @(posedge CLK) begin
		cycle_count = cycle_count + 1;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			$display("timeout: trace not finished");
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	task automatic check_value(input string sig, input logic [`WORD_W-1:0] expected,
		input logic [`WORD_W-1:0] actual);
		if (actual !== expected) begin
			$display("error at %0t: %s expected %h got %h", $time, sig, expected, actual);
			test_errs = test_errs + 1;
		end
	endtask

	// one line per finished test
	task automatic close_test();
		if (test_open != 0) begin
			if (test_errs == 0) begin
				$display("test %s: passed, %0d cycles", test_name, test_cycles);
				pass_count = pass_count + 1;
			end
			else begin
				$display("test %s: failed, %0d mismatches", test_name, test_errs);
				fail_count = fail_count + 1;
			end
		end
		test_open = 0;
	endtask

	task automatic open_test(input string line);
		close_test();
		test_name = "unnamed";
		void'($sscanf(line, "test %s", test_name));
		test_open = 1;
		test_errs = 0;
		test_cycles = 0;
	endtask

	// columns: rst instr ihit dhit rdat1 rdat2, then expected outputs
	task automatic run_cycle(input string line);
		logic [`WORD_W-1:0] v_rst;
		logic [`WORD_W-1:0] v_instr;
		logic [`WORD_W-1:0] v_ihit;
		logic [`WORD_W-1:0] v_dhit;
		logic [`WORD_W-1:0] v_rdat1;
		logic [`WORD_W-1:0] v_rdat2;
		logic [`WORD_W-1:0] e_addr;
		logic [`WORD_W-1:0] e_ren;
		logic [`WORD_W-1:0] e_wen;
		logic [`WORD_W-1:0] e_halt;
		int n;
		n = $sscanf(line, "c %h %h %h %h %h %h %h %h %h %h", v_rst, v_instr, v_ihit,
			v_dhit, v_rdat1, v_rdat2, e_addr, e_ren, e_wen, e_halt);
		if (n != 10) begin
			$display("trace line could not be read: %s", line);
			test_errs = test_errs + 1;
		end
		else begin
			// called on a falling edge
			rst = v_rst[0];
			instr = v_instr;
			ihit = v_ihit[0];
			dhit = v_dhit[0];
			rdat1 = v_rdat1;
			rdat2 = v_rdat2;
			@(posedge CLK);
			// registers settled, next falling edge still 1 ns away
			#1;
			check_value("imem_addr", e_addr, imem_addr);
			check_value("dmem_ren", e_ren, `WORD_W'(dmem_ren));
			check_value("dmem_wen", e_wen, `WORD_W'(dmem_wen));
			check_value("halt", e_halt, `WORD_W'(halt));
			test_cycles = test_cycles + 1;
			@(negedge CLK);
		end
	endtask

	initial begin
		int fd;
		string line;
		rst = 1'b1;
		instr = '0;
		ihit = 1'b0;
		dhit = 1'b0;
		rdat1 = '0;
		rdat2 = '0;

		fd = $fopen("dv/pipe_trace.txt", "r");
		if (fd == 0) begin
			$display("trace file dv/pipe_trace.txt could not be opened");
			fail_count = fail_count + 1;
		end
		else begin
			while (!$feof(fd)) begin
				line = "";
				if ($fgets(line, fd) > 0) begin
					trace_lines.push_back(line);
				end
			end
			$fclose(fd);
		end
		cycle_limit = 2 * trace_lines.size() + 20;

		// reset for three rising edges, release on a falling edge
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		rst = 1'b0;

		foreach (trace_lines[i]) begin
			// marker, cycle, anything else is a comment
			if (trace_lines[i][0] == "t") begin
				open_test(trace_lines[i]);
			end
			else if (trace_lines[i][0] == "c") begin
				run_cycle(trace_lines[i]);
			end
		end
		close_test();

		$display("tests passed %0d failed %0d", pass_count, fail_count);
		if (fail_count == 0 && pass_count > 0) begin
			$display("SIMULATION PASSED");
		end
		else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// File: include/cpu_consts.svh
// cpu constants
// datapath widths and the program counter reset value
// shared by the pipeline control RTL

`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// data word and address width
`define WORD_W 32

// register index width, 32 registers
`define REG_W 5

// first fetch address after reset
`define PC_RESET 32'h0000_0000

`endif

// File: source/cpu_pipe_pkg.sv
// cpu pipeline package
// opcode, R-type function and next-PC source encodings
// used by the hazard unit, PC unit and stage registers

package cpu_pipe_pkg;

	// opcodes seen by the pipeline control, MIPS encoding
	typedef enum logic [5:0] {
		RTYPE = 6'b000000,
		J     = 6'b000010,
		JAL   = 6'b000011,
		BEQ   = 6'b000100,
		BNE   = 6'b000101,
		ADDI  = 6'b001000,
		LW    = 6'b100011,
		SW    = 6'b101011,
		// halt is the all ones opcode
		HALT  = 6'b111111
	} opcode_t;

	// R-type function field
	typedef enum logic [5:0] {
		// sll with all zero fields doubles as the nop
		SLL = 6'b000000,
		JR  = 6'b001000
	} funct_t;

	// next-PC source select
	typedef enum logic [2:0] {
		// sequential fetch
		SEL_LOAD_NXT_INSTR     = 3'd0,
		// predicted taken branch target from decode
		SEL_LOAD_BR_ADDR       = 3'd1,
		// fall-through of a mispredicted branch
		SEL_LOAD_NXT_PC_EX_MEM = 3'd2,
		// j and jal target
		SEL_LOAD_JMP_ADDR      = 3'd3,
		// jr target from the register file
		SEL_LOAD_JR_ADDR       = 3'd4
	} pcsrc_t;

endpackage

// File: source/hazard_unit.sv
// hazard unit
// decides each cycle whether the pipeline advances, picks the
// next-PC source and the hold and flush of every stage register
// purely combinational

`timescale 1ns/100ps
`include "cpu_consts.svh"

module hazard_unit (
	input  cpu_pipe_pkg::opcode_t opcode_if_id,
	input  cpu_pipe_pkg::funct_t  func_if_id,
	input  logic [`REG_W-1:0]     rs_if_id,
	input  logic [`REG_W-1:0]     rt_if_id,
	input  logic [`REG_W-1:0]     rt_id_ex,
	input  logic                  dren_id_ex,
	input  cpu_pipe_pkg::opcode_t opcode_ex_mem,
	input  logic                  zero_ex_mem,
	input  logic                  dmem_ren,
	input  logic                  dmem_wen,
	input  logic                  ihit,
	input  logic                  dhit,
	input  logic                  halt,
	output cpu_pipe_pkg::pcsrc_t  pcsrc,
	output logic                  enable_pc,
	output logic                  enable_if_id,
	output logic                  enable_id_ex,
	output logic                  enable_ex_mem,
	output logic                  enable_mem_wb,
	output logic                  flush_if_id,
	output logic                  flush_id_ex,
	output logic                  flush_ex_mem,
	output logic                  flush_mem_wb
);

	logic data_pend;
	logic move;
	logic mispredict;
	logic load_use;

	// a load or store sits in execute/memory
	assign data_pend = dmem_ren | dmem_wen;

	always_comb begin
		move = 1'b1;
		// data access still waiting on memory
		if (data_pend && !dhit) begin
			move = 1'b0;
		end
		// no valid fetch word this cycle
		else if (!ihit) begin
			move = 1'b0;
		end
		// stray dhit with no access of ours owns the shared port,
		// fetch word is not ours to take
		else if (dhit && !data_pend) begin
			move = 1'b0;
		end
		// halt reached write-back, freeze until reset
		else if (halt) begin
			move = 1'b0;
		end
	end

	// beq not equal or bne equal went the wrong way
	assign mispredict = ((opcode_ex_mem == cpu_pipe_pkg::BEQ) && !zero_ex_mem) ||
		((opcode_ex_mem == cpu_pipe_pkg::BNE) && zero_ex_mem);

	// load in execute feeds a source of the decode instruction
	assign load_use = dren_id_ex && ((rt_id_ex == rs_if_id) || (rt_id_ex == rt_if_id));

	always_comb begin
		// back-pressure default, every stage follows move
		pcsrc = cpu_pipe_pkg::SEL_LOAD_NXT_INSTR;
		enable_pc = move;
		enable_if_id = move;
		enable_id_ex = move;
		enable_ex_mem = move;
		enable_mem_wb = move;
		flush_if_id = 1'b0;
		flush_id_ex = 1'b0;
		flush_ex_mem = 1'b0;
		// write-back never needs squashing
		flush_mem_wb = 1'b0;

		if (move) begin
			if (mispredict) begin
				// back to the fall-through, squash the wrong path
				pcsrc = cpu_pipe_pkg::SEL_LOAD_NXT_PC_EX_MEM;
				flush_if_id = 1'b1;
				flush_id_ex = 1'b1;
				flush_ex_mem = 1'b1;
			end
			else if (load_use) begin
				// one bubble, decode instruction stays put
				// so it must not redirect fetch yet
				enable_pc = 1'b0;
				enable_if_id = 1'b0;
				flush_id_ex = 1'b1;
			end
			else if ((opcode_if_id == cpu_pipe_pkg::BEQ) ||
				(opcode_if_id == cpu_pipe_pkg::BNE)) begin
				// predict taken
				pcsrc = cpu_pipe_pkg::SEL_LOAD_BR_ADDR;
				flush_if_id = 1'b1;
			end
			else if ((opcode_if_id == cpu_pipe_pkg::J) ||
				(opcode_if_id == cpu_pipe_pkg::JAL)) begin
				pcsrc = cpu_pipe_pkg::SEL_LOAD_JMP_ADDR;
				flush_if_id = 1'b1;
			end
			else if ((opcode_if_id == cpu_pipe_pkg::RTYPE) &&
				(func_if_id == cpu_pipe_pkg::JR)) begin
				// return address comes straight from rdat1
				pcsrc = cpu_pipe_pkg::SEL_LOAD_JR_ADDR;
				flush_if_id = 1'b1;
			end
		end
	end

endmodule

// File: source/pc_unit.sv
// program counter unit
// next-PC multiplexer and the PC register, loads when enabled

`timescale 1ns/100ps
`include "cpu_consts.svh"

module pc_unit (
	input  logic                 CLK,
	input  logic                 rst,
	input  logic                 enable_pc,
	input  cpu_pipe_pkg::pcsrc_t pcsrc,
	input  logic [`WORD_W-1:0]   br_addr,
	input  logic [`WORD_W-1:0]   jmp_addr,
	input  logic [`WORD_W-1:0]   nxt_pc_ex_mem,
	input  logic [`WORD_W-1:0]   jr_addr,
	output logic [`WORD_W-1:0]   pc,
	output logic [`WORD_W-1:0]   pc_plus4
);

	logic [`WORD_W-1:0] nxt_pc;

	// sequential address, also latched into IF/ID
	assign pc_plus4 = pc + `WORD_W'd4;

	always_comb begin
		case (pcsrc)
			cpu_pipe_pkg::SEL_LOAD_BR_ADDR:       nxt_pc = br_addr;
			cpu_pipe_pkg::SEL_LOAD_NXT_PC_EX_MEM: nxt_pc = nxt_pc_ex_mem;
			cpu_pipe_pkg::SEL_LOAD_JMP_ADDR:      nxt_pc = jmp_addr;
			cpu_pipe_pkg::SEL_LOAD_JR_ADDR:       nxt_pc = jr_addr;
			// SEL_LOAD_NXT_INSTR and unused codes
			default:                              nxt_pc = pc_plus4;
		endcase
	end

	// pc register, holds on stall
	always_ff @(posedge CLK) begin
		if (rst) begin
			pc <= `PC_RESET;
		end
		else if (enable_pc) begin
			pc <= nxt_pc;
		end
	end

endmodule

// File: source/pipe_regs.sv
// pipeline stage registers
// IF/ID, ID/EX, EX/MEM and MEM/WB with enable and flush to nop,
// decode field split, branch and jump targets, execute compare

`timescale 1ns/100ps
`include "cpu_consts.svh"

module pipe_regs (
	input  logic                  CLK,
	input  logic                  rst,
	input  logic [`WORD_W-1:0]    instr,
	input  logic [`WORD_W-1:0]    pc_plus4,
	input  logic [`WORD_W-1:0]    rdat1,
	input  logic [`WORD_W-1:0]    rdat2,
	input  logic                  enable_if_id,
	input  logic                  enable_id_ex,
	input  logic                  enable_ex_mem,
	input  logic                  enable_mem_wb,
	input  logic                  flush_if_id,
	input  logic                  flush_id_ex,
	input  logic                  flush_ex_mem,
	input  logic                  flush_mem_wb,
	output cpu_pipe_pkg::opcode_t opcode_if_id,
	output cpu_pipe_pkg::funct_t  func_if_id,
	output logic [`REG_W-1:0]     rs_if_id,
	output logic [`REG_W-1:0]     rt_if_id,
	output logic [`REG_W-1:0]     rt_id_ex,
	output logic                  dren_id_ex,
	output cpu_pipe_pkg::opcode_t opcode_ex_mem,
	output logic                  zero_ex_mem,
	output logic [`WORD_W-1:0]    br_addr,
	output logic [`WORD_W-1:0]    jmp_addr,
	output logic [`WORD_W-1:0]    nxt_pc_ex_mem,
	output logic                  dmem_ren,
	output logic                  dmem_wen,
	output logic                  halt
);

	logic [`WORD_W-1:0]    instr_if_id;
	logic [`WORD_W-1:0]    pc4_if_id;
	logic [15:0]           imm_if_id;
	cpu_pipe_pkg::opcode_t opcode_id_ex;
	logic [`WORD_W-1:0]    nxt_pc_id_ex;
	logic [`WORD_W-1:0]    rdat1_id_ex;
	logic [`WORD_W-1:0]    rdat2_id_ex;
	logic                  zero_ex;
	cpu_pipe_pkg::opcode_t opcode_mem_wb;

	// IF/ID, a flush drops the fetched word for a nop
	always_ff @(posedge CLK) begin
		if (rst || flush_if_id) begin
			instr_if_id <= '0;
		end
		else if (enable_if_id) begin
			instr_if_id <= instr;
		end
	end

	always_ff @(posedge CLK) begin
		if (enable_if_id) begin
			pc4_if_id <= pc_plus4;
		end
	end

	// decode fields
	assign opcode_if_id = cpu_pipe_pkg::opcode_t'(instr_if_id[31:26]);
	assign rs_if_id = instr_if_id[25:21];
	assign rt_if_id = instr_if_id[20:16];
	assign imm_if_id = instr_if_id[15:0];
	assign func_if_id = cpu_pipe_pkg::funct_t'(instr_if_id[5:0]);

	// branch target, word offset relative to pc plus 4
	assign br_addr = pc4_if_id + {{14{imm_if_id[15]}}, imm_if_id, 2'b00};
	// jump target keeps the upper nibble of pc plus 4
	assign jmp_addr = {pc4_if_id[31:28], instr_if_id[25:0], 2'b00};

	// ID/EX control, load flag marks a possible load-use source
	always_ff @(posedge CLK) begin
		if (rst || flush_id_ex) begin
			opcode_id_ex <= cpu_pipe_pkg::RTYPE;
			rt_id_ex <= '0;
			dren_id_ex <= 1'b0;
		end
		else if (enable_id_ex) begin
			opcode_id_ex <= opcode_if_id;
			rt_id_ex <= rt_if_id;
			dren_id_ex <= (opcode_if_id == cpu_pipe_pkg::LW);
		end
	end

	// ID/EX payload, fall-through and branch operands
	always_ff @(posedge CLK) begin
		if (enable_id_ex) begin
			nxt_pc_id_ex <= pc4_if_id;
			rdat1_id_ex <= rdat1;
			rdat2_id_ex <= rdat2;
		end
	end

	// execute compare for beq and bne
	assign zero_ex = (rdat1_id_ex == rdat2_id_ex);

	// EX/MEM control
	always_ff @(posedge CLK) begin
		if (rst || flush_ex_mem) begin
			opcode_ex_mem <= cpu_pipe_pkg::RTYPE;
			zero_ex_mem <= 1'b0;
		end
		else if (enable_ex_mem) begin
			opcode_ex_mem <= opcode_id_ex;
			zero_ex_mem <= zero_ex;
		end
	end

	// saved fall-through for the misprediction path
	always_ff @(posedge CLK) begin
		if (enable_ex_mem) begin
			nxt_pc_ex_mem <= nxt_pc_id_ex;
		end
	end

	// memory requests stay up while the access sits in EX/MEM
	assign dmem_ren = (opcode_ex_mem == cpu_pipe_pkg::LW);
	assign dmem_wen = (opcode_ex_mem == cpu_pipe_pkg::SW);

	// MEM/WB
	always_ff @(posedge CLK) begin
		if (rst || flush_mem_wb) begin
			opcode_mem_wb <= cpu_pipe_pkg::RTYPE;
		end
		else if (enable_mem_wb) begin
			opcode_mem_wb <= opcode_ex_mem;
		end
	end

	assign halt = (opcode_mem_wb == cpu_pipe_pkg::HALT);

endmodule

// File: source/pipeline_ctrl_top.sv
// pipeline control top level
// hazard unit, program counter unit and stage registers

`timescale 1ns/100ps
`include "cpu_consts.svh"

module pipeline_ctrl_top (
	input  logic               CLK,
	input  logic               rst,
	input  logic [`WORD_W-1:0] instr,
	input  logic               ihit,
	input  logic               dhit,
	input  logic [`WORD_W-1:0] rdat1,
	input  logic [`WORD_W-1:0] rdat2,
	output logic [`WORD_W-1:0] imem_addr,
	output logic               dmem_ren,
	output logic               dmem_wen,
	output logic               halt
);

	// decode and execute fields into the hazard unit
	cpu_pipe_pkg::opcode_t opcode_if_id;
	cpu_pipe_pkg::funct_t  func_if_id;
	logic [`REG_W-1:0]     rs_if_id;
	logic [`REG_W-1:0]     rt_if_id;
	logic [`REG_W-1:0]     rt_id_ex;
	logic                  dren_id_ex;
	cpu_pipe_pkg::opcode_t opcode_ex_mem;
	logic                  zero_ex_mem;
	// hazard unit decisions
	cpu_pipe_pkg::pcsrc_t  pcsrc;
	logic                  enable_pc;
	logic                  enable_if_id;
	logic                  enable_id_ex;
	logic                  enable_ex_mem;
	logic                  enable_mem_wb;
	logic                  flush_if_id;
	logic                  flush_id_ex;
	logic                  flush_ex_mem;
	logic                  flush_mem_wb;
	// addresses between pc unit and stage registers
	logic [`WORD_W-1:0]    br_addr;
	logic [`WORD_W-1:0]    jmp_addr;
	logic [`WORD_W-1:0]    nxt_pc_ex_mem;
	logic [`WORD_W-1:0]    pc_plus4;

	hazard_unit u_hazard (
		.opcode_if_id  (opcode_if_id),
		.func_if_id    (func_if_id),
		.rs_if_id      (rs_if_id),
		.rt_if_id      (rt_if_id),
		.rt_id_ex      (rt_id_ex),
		.dren_id_ex    (dren_id_ex),
		.opcode_ex_mem (opcode_ex_mem),
		.zero_ex_mem   (zero_ex_mem),
		.dmem_ren      (dmem_ren),
		.dmem_wen      (dmem_wen),
		.ihit          (ihit),
		.dhit          (dhit),
		.halt          (halt),
		.pcsrc         (pcsrc),
		.enable_pc     (enable_pc),
		.enable_if_id  (enable_if_id),
		.enable_id_ex  (enable_id_ex),
		.enable_ex_mem (enable_ex_mem),
		.enable_mem_wb (enable_mem_wb),
		.flush_if_id   (flush_if_id),
		.flush_id_ex   (flush_id_ex),
		.flush_ex_mem  (flush_ex_mem),
		.flush_mem_wb  (flush_mem_wb)
	);

	// pc drives the instruction memory address directly
	// jr target is the rs value read in decode
	pc_unit u_pc (
		.CLK           (CLK),
		.rst           (rst),
		.enable_pc     (enable_pc),
		.pcsrc         (pcsrc),
		.br_addr       (br_addr),
		.jmp_addr      (jmp_addr),
		.nxt_pc_ex_mem (nxt_pc_ex_mem),
		.jr_addr       (rdat1),
		.pc            (imem_addr),
		.pc_plus4      (pc_plus4)
	);

	pipe_regs u_regs (
		.CLK           (CLK),
		.rst           (rst),
		.instr         (instr),
		.pc_plus4      (pc_plus4),
		.rdat1         (rdat1),
		.rdat2         (rdat2),
		.enable_if_id  (enable_if_id),
		.enable_id_ex  (enable_id_ex),
		.enable_ex_mem (enable_ex_mem),
		.enable_mem_wb (enable_mem_wb),
		.flush_if_id   (flush_if_id),
		.flush_id_ex   (flush_id_ex),
		.flush_ex_mem  (flush_ex_mem),
		.flush_mem_wb  (flush_mem_wb),
		.opcode_if_id  (opcode_if_id),
		.func_if_id    (func_if_id),
		.rs_if_id      (rs_if_id),
		.rt_if_id      (rt_if_id),
		.rt_id_ex      (rt_id_ex),
		.dren_id_ex    (dren_id_ex),
		.opcode_ex_mem (opcode_ex_mem),
		.zero_ex_mem   (zero_ex_mem),
		.br_addr       (br_addr),
		.jmp_addr      (jmp_addr),
		.nxt_pc_ex_mem (nxt_pc_ex_mem),
		.dmem_ren      (dmem_ren),
		.dmem_wen      (dmem_wen),
		.halt          (halt)
	);

endmodule

// File: tb.f
+incdir+include
source/cpu_pipe_pkg.sv
source/hazard_unit.sv
source/pc_unit.sv
source/pipe_regs.sv
source/pipeline_ctrl_top.sv
dv/tb_clock_gen.sv
dv/tb_pipeline_ctrl.sv
